/* source/board_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants for the board controller target.
// Address width and byte count size are fixed here because
// the address union is built from them.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package board_pkg;

   // host bus geometry
   localparam int usb_addr_width = 20;
   localparam int bytecnt_size   = 7;                               // low bits count bytes
   localparam int reg_addr_width = usb_addr_width - bytecnt_size;   // 13 bits

   // one bus address word, seen either raw or as register address over byte count
   typedef struct packed {
      logic [reg_addr_width-1:0] reg_addr;
      logic [bytecnt_size-1:0]   bytecnt;
   } usb_addr_fields_t;

   typedef union packed {
      logic [usb_addr_width-1:0] raw;
      usb_addr_fields_t          fields;
   } usb_addr_u;

   // register map
   localparam logic [reg_addr_width-1:0] reg_ident    = 13'd0;  // read only
   localparam logic [reg_addr_width-1:0] reg_leds     = 13'd1;
   localparam logic [reg_addr_width-1:0] reg_control  = 13'd2;
   localparam logic [reg_addr_width-1:0] reg_sram_top = 13'd3;
   localparam logic [reg_addr_width-1:0] reg_status   = 13'd4;  // read only
   localparam logic [reg_addr_width-1:0] reg_dip      = 13'd5;  // read only

   localparam logic [7:0] ident_value = 8'h2E;

   // control register bits
   localparam int ctrl_heartbeat_bit = 0;
   localparam int ctrl_sram_en_bit   = 1;

   // SRAM test data is the low address byte xor this key
   localparam logic [7:0] sram_pattern_key = 8'h5A;

endpackage

/* source/usb_reg_frontend.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host bus front end. All bus inputs are sampled once, so
// strobes must stay low for at least 3 clock cycles.
// Read data comes already registered from the register file.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module usb_reg_frontend (
   input  logic                                usb_clk_buf,
   input  logic                                reset,
   input  logic [7:0]                          usb_data_i,
   input  board_pkg::usb_addr_u                usb_addr_i,
   input  logic                                usb_rd_n_i,
   input  logic                                usb_wr_n_i,
   input  logic                                usb_ce_n_i,
   input  logic [7:0]                          reg_rdata_i,
   output logic [7:0]                          usb_data_o,
   output logic                                usb_data_oe_o,
   output logic [board_pkg::reg_addr_width-1:0] reg_address_o,
   output logic [board_pkg::bytecnt_size-1:0]   reg_bytecnt_o,
   output logic [7:0]                          reg_wdata_o,
   output logic                                reg_write_o,
   output logic                                reg_read_o
);
   import board_pkg::*;

   usb_addr_u  addr_q;      // sampled bus address
   logic [7:0] data_q;      // sampled write data
   logic       rd_n_q;
   logic       wr_n_q;
   logic       ce_n_q;
   logic       rd_n_qq;     // previous sample, for edge detect
   logic       wr_n_qq;

   // payload sampling
   always_ff @(posedge usb_clk_buf) begin
      addr_q.raw <= usb_addr_i.raw;
      data_q     <= usb_data_i;
   end

   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         rd_n_q        <= 1'b1;
         wr_n_q        <= 1'b1;
         ce_n_q        <= 1'b1;
         rd_n_qq       <= 1'b1;
         wr_n_qq       <= 1'b1;
         reg_write_o   <= 1'b0;
         reg_read_o    <= 1'b0;
         usb_data_oe_o <= 1'b0;
      end else begin
         rd_n_q        <= usb_rd_n_i;
         wr_n_q        <= usb_wr_n_i;
         ce_n_q        <= usb_ce_n_i;
         rd_n_qq       <= rd_n_q;
         wr_n_qq       <= wr_n_q;
         reg_write_o   <= wr_n_qq & ~wr_n_q & ~ce_n_q;   // falling wr_n
         reg_read_o    <= rd_n_qq & ~rd_n_q & ~ce_n_q;   // falling rd_n
         usb_data_oe_o <= ~rd_n_q & ~ce_n_q;             // drive while read held
      end
   end

   // split the sampled word through the field view
   assign reg_address_o = addr_q.fields.reg_addr;
   assign reg_bytecnt_o = addr_q.fields.bytecnt;
   assign reg_wdata_o   = data_q;
   assign usb_data_o    = reg_rdata_i;   // captured on reg_read in the register file

endmodule

/* source/board_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control and status registers, one byte each.
// Only byte count zero is decoded; other offsets read 0
// and drop writes. Ident, status and DIP are read only.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module board_regs (
   input  logic                                usb_clk_buf,
   input  logic                                reset,
   input  logic [board_pkg::reg_addr_width-1:0] reg_address_i,
   input  logic [board_pkg::bytecnt_size-1:0]   reg_bytecnt_i,
   input  logic [7:0]                          reg_wdata_i,
   input  logic                                reg_write_i,
   input  logic                                reg_read_i,
   input  logic [7:0]                          usr_dip_i,
   input  logic                                sram_pass_i,
   input  logic                                sram_fail_i,
   output logic [7:0]                          reg_rdata_o,
   output logic [7:0]                          led_value_o,
   output logic                                heartbeat_sel_o,
   output logic                                sram_en_o,
   output logic [7:0]                          sram_top_o
);
   import board_pkg::*;

   logic [7:0] leds_q;
   logic [7:0] control_q;
   logic [7:0] sram_top_q;
   logic [7:0] status;
   logic [7:0] read_mux;
   logic       byte0;          // access targets byte 0

   assign byte0  = (reg_bytecnt_i == '0);
   assign status = {6'b0, sram_fail_i, sram_pass_i};

   // write decode
   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         leds_q     <= 8'h00;
         control_q  <= 8'h00;
         sram_top_q <= 8'h00;
      end else if (reg_write_i && byte0) begin
         case (reg_address_i)
            reg_leds:     leds_q     <= reg_wdata_i;
            reg_control:  control_q  <= reg_wdata_i;
            reg_sram_top: sram_top_q <= reg_wdata_i;
            default:      ;                             // read only or unmapped
         endcase
      end
   end

   // read mux
   always_comb begin
      case (reg_address_i)
         reg_ident:    read_mux = ident_value;
         reg_leds:     read_mux = leds_q;
         reg_control:  read_mux = control_q;
         reg_sram_top: read_mux = sram_top_q;
         reg_status:   read_mux = status;
         reg_dip:      read_mux = usr_dip_i;
         default:      read_mux = 8'h00;
      endcase
   end

   // read data held until the next read
   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         reg_rdata_o <= 8'h00;
      end else if (reg_read_i) begin
         reg_rdata_o <= byte0 ? read_mux : 8'h00;
      end
   end

   assign led_value_o     = leds_q;
   assign heartbeat_sel_o = control_q[ctrl_heartbeat_bit];
   assign sram_en_o       = control_q[ctrl_sram_en_bit];
   assign sram_top_o      = sram_top_q;

endmodule

/* source/sram_rwtest.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Write/read self-test for an 8-bit asynchronous SRAM.
// One access per clock, so the SRAM must settle in a cycle.
// sram_addr_width must be at least 8.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sram_rwtest #(
   parameter int sram_addr_width = 20
) (
   input  logic                       usb_clk_buf,
   input  logic                       reset,
   input  logic                       sram_en_i,
   input  logic [7:0]                 sram_top_i,
   input  logic [7:0]                 sram_dq_i,
   output logic                       sram_pass_o,
   output logic                       sram_fail_o,
   output logic [sram_addr_width-1:0] sram_addr_o,
   output logic [7:0]                 sram_dq_o,
   output logic                       sram_dq_oe_o,
   output logic                       sram_we_n_o,
   output logic                       sram_oe_n_o,
   output logic                       sram_ce_n_o,
   output logic                       sram_ce2_o
);
   import board_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_write,
      st_read,
      st_pass,
      st_fail
   } state_t;

   state_t                     state;
   logic                       en_q;        // for start edge
   logic [sram_addr_width-1:0] addr_q;
   logic [sram_addr_width-1:0] end_addr;
   logic [7:0]                 expected;

   assign end_addr = {sram_top_i, {(sram_addr_width-8){1'b1}}};
   assign expected = addr_q[7:0] ^ sram_pattern_key;

   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         state  <= st_idle;
         en_q   <= 1'b0;
         addr_q <= '0;
      end else begin
         en_q <= sram_en_i;
         if (!sram_en_i) begin
            state  <= st_idle;                       // result cleared with enable
            addr_q <= '0;
         end else begin
            case (state)
               st_idle: begin
                  addr_q <= '0;
                  if (!en_q) state <= st_write;        // rising enable
               end
               st_write: begin
                  if (addr_q == end_addr) begin
                     addr_q <= '0;
                     state  <= st_read;
                  end else begin
                     addr_q <= addr_q + 1'b1;
                  end
               end
               st_read: begin
                  if (sram_dq_i != expected) state <= st_fail;   // stop at first miss
                  else if (addr_q == end_addr) state <= st_pass;
                  else addr_q <= addr_q + 1'b1;
               end
               default: ;                                          // hold result
            endcase
         end
      end
   end

   // SRAM strobes follow the state
   assign sram_addr_o  = addr_q;
   assign sram_dq_o    = expected;
   assign sram_dq_oe_o = (state == st_write);
   assign sram_we_n_o  = ~(state == st_write);
   assign sram_oe_n_o  = ~(state == st_read);
   assign sram_ce_n_o  = ~((state == st_write) || (state == st_read));
   assign sram_ce2_o   = (state == st_write) || (state == st_read);
   assign sram_pass_o  = (state == st_pass);
   assign sram_fail_o  = (state == st_fail);

endmodule

/* source/led_driver.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LED output: heartbeat on LED 0 or the LED register.
// Heartbeat period is 2^heartbeat_bits clock cycles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module led_driver #(
   parameter int heartbeat_bits = 25
) (
   input  logic       usb_clk_buf,
   input  logic       reset,
   input  logic       heartbeat_sel_i,
   input  logic [7:0] led_value_i,
   output logic [7:0] usr_led_o
);

   logic [heartbeat_bits-1:0] heartbeat_q;   // free running

   always_ff @(posedge usb_clk_buf) begin
      if (reset) begin
         heartbeat_q <= '0;
      end else begin
         heartbeat_q <= heartbeat_q + 1'b1;
      end
   end

   // top counter bit blinks LED 0
   assign usr_led_o = heartbeat_sel_i ? {7'b0, heartbeat_q[heartbeat_bits-1]}
                                      : led_value_i;

endmodule

/* source/board_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board controller target, single clock usb_clk_buf.
// Bidirectional pins are split into in, out and enable;
// the tristate buffers belong in the pad wrapper.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module board_top #(
   parameter int heartbeat_bits  = 25,
   parameter int sram_addr_width = 20
) (
   input  logic                                usb_clk_buf,
   input  logic                                reset,
   // host bus
   input  logic [7:0]                          usb_data_i,
   input  logic [board_pkg::usb_addr_width-1:0] usb_addr_i,
   input  logic                                usb_rd_n_i,
   input  logic                                usb_wr_n_i,
   input  logic                                usb_ce_n_i,
   output logic [7:0]                          usb_data_o,
   output logic                                usb_data_oe_o,
   // user I/O
   input  logic [7:0]                          usr_dip_i,
   output logic [7:0]                          usr_led_o,
   // SRAM
   output logic [sram_addr_width-1:0]          sram_addr_o,
   input  logic [7:0]                          sram_dq_i,
   output logic [7:0]                          sram_dq_o,
   output logic                                sram_dq_oe_o,
   output logic                                sram_we_n_o,
   output logic                                sram_oe_n_o,
   output logic                                sram_ce_n_o,
   output logic                                sram_ce2_o
);
   import board_pkg::*;

   logic [reg_addr_width-1:0] reg_address;
   logic [bytecnt_size-1:0]   reg_bytecnt;
   logic [7:0]                reg_wdata;
   logic [7:0]                reg_rdata;
   logic                      reg_write;
   logic                      reg_read;
   logic [7:0]                led_value;
   logic                      heartbeat_sel;
   logic                      sram_en;
   logic [7:0]                sram_top;
   logic                      sram_pass;
   logic                      sram_fail;

   // input side
   usb_reg_frontend usb_reg_frontend_i (
      .usb_clk_buf   (usb_clk_buf),
      .reset         (reset),
      .usb_data_i    (usb_data_i),
      .usb_addr_i    (usb_addr_i),      // raw word into the address union
      .usb_rd_n_i    (usb_rd_n_i),
      .usb_wr_n_i    (usb_wr_n_i),
      .usb_ce_n_i    (usb_ce_n_i),
      .reg_rdata_i   (reg_rdata),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .reg_address_o (reg_address),
      .reg_bytecnt_o (reg_bytecnt),
      .reg_wdata_o   (reg_wdata),
      .reg_write_o   (reg_write),
      .reg_read_o    (reg_read)
   );

   board_regs board_regs_i (
      .usb_clk_buf     (usb_clk_buf),
      .reset           (reset),
      .reg_address_i   (reg_address),
      .reg_bytecnt_i   (reg_bytecnt),
      .reg_wdata_i     (reg_wdata),
      .reg_write_i     (reg_write),
      .reg_read_i      (reg_read),
      .usr_dip_i       (usr_dip_i),
      .sram_pass_i     (sram_pass),
      .sram_fail_i     (sram_fail),
      .reg_rdata_o     (reg_rdata),
      .led_value_o     (led_value),
      .heartbeat_sel_o (heartbeat_sel),
      .sram_en_o       (sram_en),
      .sram_top_o      (sram_top)
   );

   sram_rwtest #(
      .sram_addr_width (sram_addr_width)
   ) sram_rwtest_i (
      .usb_clk_buf  (usb_clk_buf),
      .reset        (reset),
      .sram_en_i    (sram_en),
      .sram_top_i   (sram_top),
      .sram_dq_i    (sram_dq_i),
      .sram_pass_o  (sram_pass),
      .sram_fail_o  (sram_fail),
      .sram_addr_o  (sram_addr_o),
      .sram_dq_o    (sram_dq_o),
      .sram_dq_oe_o (sram_dq_oe_o),
      .sram_we_n_o  (sram_we_n_o),
      .sram_oe_n_o  (sram_oe_n_o),
      .sram_ce_n_o  (sram_ce_n_o),
      .sram_ce2_o   (sram_ce2_o)
   );

   // output side
   led_driver #(
      .heartbeat_bits (heartbeat_bits)
   ) led_driver_i (
      .usb_clk_buf     (usb_clk_buf),
      .reset           (reset),
      .heartbeat_sel_i (heartbeat_sel),
      .led_value_i     (led_value),
      .usr_led_o       (usr_led_o)
   );

endmodule

/* tb/sram_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Behavioral 8-bit asynchronous SRAM for simulation only.
// A write lands at the clock edge that closes the cycle.
// One address can be set to read back inverted.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module sram_model #(
   parameter int addr_width = 10
) (
   input  logic                  usb_clk_buf,
   input  logic [addr_width-1:0] addr_i,
   input  logic [7:0]            dq_i,
   input  logic                  dq_oe_i,
   input  logic                  we_n_i,
   input  logic                  oe_n_i,
   input  logic                  ce_n_i,
   input  logic                  ce2_i,
   input  logic                  corrupt_en_i,
   input  logic [addr_width-1:0] corrupt_addr_i,
   output logic [7:0]            dq_o
);

   logic [7:0]            mem [0:(1<<addr_width)-1];
   logic [addr_width-1:0] fill_addr;
   logic                  selected;
   logic [7:0]            flip;

   initial begin
      for (int i = 0; i < (1 << addr_width); i++) begin
         fill_addr      = addr_width'(i);
         mem[fill_addr] = 8'(i) ^ 8'(i >> 8) ^ 8'(i >> 16) ^ 8'hC3;   // differs from test data
      end
   end

   assign selected = ~ce_n_i & ce2_i;
   assign flip     = (corrupt_en_i && addr_i == corrupt_addr_i) ? 8'hFF : 8'h00;

   always @(posedge usb_clk_buf) begin
      if (selected && !we_n_i && dq_oe_i) begin
         mem[addr_i] = dq_i;
      end
   end

   assign dq_o = (selected && !oe_n_i) ? (mem[addr_i] ^ flip) : 8'h00;   // bus idles at 0

endmodule

/* tb/tb_board_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Directed testbench for board_top with a small heartbeat
// and a 10-bit SRAM. Stops at the first failing check.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_board_top;
   import board_pkg::*;

   localparam int hb_bits   = 6;
   localparam int sram_aw   = 10;
   localparam int num_tests = 5;
   localparam int budget_ns = num_tests * 3000;

   logic                      usb_clk_buf = 1'b0;
   logic                      reset;
   logic [7:0]                usb_data_i;
   logic [usb_addr_width-1:0] usb_addr_i;
   logic                      usb_rd_n_i;
   logic                      usb_wr_n_i;
   logic                      usb_ce_n_i;
   logic [7:0]                usb_data_o;
   logic                      usb_data_oe_o;
   logic [7:0]                usr_dip_i;
   logic [7:0]                usr_led_o;
   logic [sram_aw-1:0]        sram_addr;
   logic [7:0]                sram_rd_data;     // model to DUT
   logic [7:0]                sram_wr_data;     // DUT to model
   logic                      sram_dq_oe;
   logic                      sram_we_n;
   logic                      sram_oe_n;
   logic                      sram_ce_n;
   logic                      sram_ce2;
   logic                      corrupt_en;
   logic [sram_aw-1:0]        corrupt_addr;
   logic [31:0]               lfsr_state = 32'he3a14519;
   int                        err_count  = 0;

   always #4 usb_clk_buf = ~usb_clk_buf;

   board_top #(
      .heartbeat_bits  (hb_bits),
      .sram_addr_width (sram_aw)
   ) board_top_i (
      .usb_clk_buf   (usb_clk_buf),
      .reset         (reset),
      .usb_data_i    (usb_data_i),
      .usb_addr_i    (usb_addr_i),
      .usb_rd_n_i    (usb_rd_n_i),
      .usb_wr_n_i    (usb_wr_n_i),
      .usb_ce_n_i    (usb_ce_n_i),
      .usb_data_o    (usb_data_o),
      .usb_data_oe_o (usb_data_oe_o),
      .usr_dip_i     (usr_dip_i),
      .usr_led_o     (usr_led_o),
      .sram_addr_o   (sram_addr),
      .sram_dq_i     (sram_rd_data),
      .sram_dq_o     (sram_wr_data),
      .sram_dq_oe_o  (sram_dq_oe),
      .sram_we_n_o   (sram_we_n),
      .sram_oe_n_o   (sram_oe_n),
      .sram_ce_n_o   (sram_ce_n),
      .sram_ce2_o    (sram_ce2)
   );

   sram_model #(
      .addr_width (sram_aw)
   ) sram_model_i (
      .usb_clk_buf    (usb_clk_buf),
      .addr_i         (sram_addr),
      .dq_i           (sram_wr_data),
      .dq_oe_i        (sram_dq_oe),
      .we_n_i         (sram_we_n),
      .oe_n_i         (sram_oe_n),
      .ce_n_i         (sram_ce_n),
      .ce2_i          (sram_ce2),
      .corrupt_en_i   (corrupt_en),
      .corrupt_addr_i (corrupt_addr),
      .dq_o           (sram_rd_data)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
   endfunction

   task automatic random_byte(output logic [7:0] b);
      b = 8'h00;
      for (int i = 0; i < 8; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         b          = {b[6:0], lfsr_state[0]};
      end
   endtask

   task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         err_count++;
         $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                  $time, what, actual, expected);
         $display("Errors found");
         $fatal(1, "stopped at first failing check");
      end
   endtask

   // strobe held 5 cycles, then an idle gap so the next falling edge is seen
   task automatic bus_write(input logic [reg_addr_width-1:0] reg_addr,
                            input logic [bytecnt_size-1:0] bytecnt, input logic [7:0] data);
      @(negedge usb_clk_buf);
      usb_addr_i = {reg_addr, bytecnt};
      usb_data_i = data;
      usb_ce_n_i = 1'b0;
      usb_wr_n_i = 1'b0;
      repeat (5) @(negedge usb_clk_buf);
      usb_wr_n_i = 1'b1;
      usb_ce_n_i = 1'b1;
      repeat (3) @(negedge usb_clk_buf);
   endtask

   task automatic bus_read(input logic [reg_addr_width-1:0] reg_addr,
                           input logic [bytecnt_size-1:0] bytecnt, output logic [7:0] data);
      @(negedge usb_clk_buf);
      usb_addr_i = {reg_addr, bytecnt};
      usb_ce_n_i = 1'b0;
      usb_rd_n_i = 1'b0;
      repeat (4) @(negedge usb_clk_buf);                  // fifth cycle of the strobe
      check_equal(32'(usb_data_oe_o), 32'd1, "data enable during read");
      data = usb_data_o;
      @(negedge usb_clk_buf);
      usb_rd_n_i = 1'b1;
      usb_ce_n_i = 1'b1;
      repeat (3) @(negedge usb_clk_buf);
      check_equal(32'(usb_data_oe_o), 32'd0, "data enable after read");
   endtask

   task automatic ident_and_dip_readback();
      logic [7:0] dip;
      logic [7:0] r;
      bus_read(reg_ident, 7'd0, r);
      check_equal(32'(r), 32'(ident_value), "identification byte");
      random_byte(dip);
      @(negedge usb_clk_buf);
      usr_dip_i = dip;
      bus_read(reg_dip, 7'd0, r);
      check_equal(32'(r), 32'(dip), "DIP switch readback");
   endtask

   task automatic led_register_access();
      logic [7:0] v;
      logic [7:0] r;
      v = 8'h00;
      for (int i = 0; i < 4; i++) begin
         random_byte(v);
         bus_write(reg_leds, 7'd0, v);
         bus_read(reg_leds, 7'd0, r);
         check_equal(32'(r), 32'(v), "LED register readback");
         check_equal(32'(usr_led_o), 32'(v), "LED pins show register");
      end
      bus_write(reg_leds, 7'd1, ~v);                      // byte 1 is not decoded
      bus_read(reg_leds, 7'd0, r);
      check_equal(32'(r), 32'(v), "write with nonzero byte count");
      bus_read(reg_leds, 7'd3, r);
      check_equal(32'(r), 32'd0, "read with nonzero byte count");
      bus_write(reg_ident, 7'd0, ~ident_value);
      bus_read(reg_ident, 7'd0, r);
      check_equal(32'(r), 32'(ident_value), "write to read-only ident");
   endtask

   task automatic heartbeat_blink();
      logic       first;
      logic       toggled;
      logic [7:0] saved;
      random_byte(saved);
      bus_write(reg_leds, 7'd0, saved);                   // known value to come back to
      bus_write(reg_control, 7'd0, 8'(1 << ctrl_heartbeat_bit));
      first   = usr_led_o[0];
      toggled = 1'b0;
      for (int i = 0; i < (1 << hb_bits); i++) begin
         @(negedge usb_clk_buf);
         check_equal(32'(usr_led_o[7:1]), 32'd0, "upper LEDs in heartbeat mode");
         if (usr_led_o[0] != first) toggled = 1'b1;
      end
      check_equal(32'(toggled), 32'd1, "heartbeat LED toggle");
      bus_write(reg_control, 7'd0, 8'h00);
      check_equal(32'(usr_led_o), 32'(saved), "LED register shown again");
   endtask

   task automatic sram_selftest_pass();
      logic [7:0]         s;
      logic [sram_aw-1:0] last;
      bus_write(reg_sram_top, 7'd0, 8'h03);
      bus_write(reg_control, 7'd0, 8'(1 << ctrl_sram_en_bit));
      s = 8'h00;
      while (s == 8'h00) bus_read(reg_status, 7'd0, s);
      check_equal(32'(s), 32'h01, "status after clean SRAM test");
      last = {8'h03, {(sram_aw-8){1'b1}}};                // top byte over all ones
      for (int a = 0; a <= int'(last); a++) begin
         check_equal(32'(sram_model_i.mem[sram_aw'(a)]), 32'(8'(a) ^ sram_pattern_key),
                     $sformatf("SRAM content at address %0d", a));
      end
   endtask

   task automatic sram_selftest_fail();
      logic [7:0] s;
      bus_write(reg_control, 7'd0, 8'h00);
      bus_read(reg_status, 7'd0, s);
      check_equal(32'(s), 32'd0, "status after enable cleared");
      @(negedge usb_clk_buf);
      corrupt_addr = sram_aw'(9);
      corrupt_en   = 1'b1;
      bus_write(reg_control, 7'd0, 8'(1 << ctrl_sram_en_bit));
      s = 8'h00;
      while (s == 8'h00) bus_read(reg_status, 7'd0, s);
      check_equal(32'(s), 32'h02, "status with corrupted address");
      check_equal(32'(sram_addr), 32'd9, "test stops at first bad address");
   endtask

   initial begin
      reset        = 1'b1;
      usb_data_i   = 8'h00;
      usb_addr_i   = '0;
      usb_rd_n_i   = 1'b1;
      usb_wr_n_i   = 1'b1;
      usb_ce_n_i   = 1'b1;
      usr_dip_i    = 8'h00;
      corrupt_en   = 1'b0;
      corrupt_addr = '0;
      repeat (8) @(negedge usb_clk_buf);
      reset = 1'b0;
      check_equal(32'(usb_data_oe_o), 32'd0, "data enable after reset");
      check_equal(32'({sram_we_n, sram_oe_n, sram_ce_n, sram_ce2}), 32'b1110,
                  "SRAM strobes after reset");
      check_equal(32'(usr_led_o), 32'd0, "LEDs after reset");
      ident_and_dip_readback();
      led_register_access();
      heartbeat_blink();
      sram_selftest_pass();
      sram_selftest_fail();
      if (err_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   // watchdog sized from the number of tests
   initial begin
      #(budget_ns);
      $display("Timeout: the tests did not finish within %0d ns", budget_ns);
      $display("Errors found");
      $fatal(1, "watchdog expired");
   end

endmodule

/* files.f */
source/board_pkg.sv
source/usb_reg_frontend.sv
source/board_regs.sv
source/sram_rwtest.sv
source/led_driver.sv
source/board_top.sv
tb/sram_model.sv
tb/tb_board_top.sv

/* Makefile */
# Verilator build and run for the board controller testbench

VERILATOR ?= verilator
TOP       ?= tb_board_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FILELIST  ?= files.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) $(VFLAGS) -f $(FILELIST)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "No errors" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
